// File: verilog.f
+incdir+common
common/stackPkg.sv
stack/stackMemory.sv
stack/stackCore.sv
verilog/stackRegs.sv
verilog/stackTop.sv
tb/stack_properties.sv
tb/stackTb.sv

// File: run.sh
#!/bin/sh
# build and run the stack testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module stackTb -o stackSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/stackSim > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi
exit 0

// File: tb/stackTb.sv
// ----------------------------------------------------------------------
// directed table test of stackTop with inputs changing on the falling edge
// first table part runs with all limits 0, second with AXI limits 4/4/1
// expected memory contents are tracked to check nos and third
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "stack_cfg.svh"

module stackTb;

  import stackPkg::*;

  typedef logic [`STACK_WIDTH-1:0]    stackWord;
  typedef logic [`STACK_IDX_BITS-1:0] idxWord;

  typedef struct {
    string      name;
    stackOp     op;
    stackWord   data;
    idxWord     offset;
    logic       dropTos;
    stackStatus expStatus;
    idxWord     expIndex;
    stackWord   expTos;
  } tableEntry;

  localparam int AxiCycles = 20;                 // wait limit per AXI phase
  localparam int AxiOps    = 12;
  localparam int CmdCycles = `STACK_DEPTH + 10;  // longest fill plus slack
  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

  logic clk;
  logic reset;
  stackCmd cmd;
  logic cmdValid;
  logic cmdReady;
  stackView resp;
  logic respValid;
  logic [`AXI_ADDR_BITS-1:0] awaddr;
  logic awvalid;
  logic awready;
  logic [`AXI_DATA_BITS-1:0] wdata;
  logic wvalid;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready;
  logic [`AXI_ADDR_BITS-1:0] araddr;
  logic arvalid;
  logic arready;
  logic [`AXI_DATA_BITS-1:0] rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;

  tableEntry steps[$];
  int splitAt;       // first entry that runs with the AXI limits
  logic tableReady;

  stackWord shadow [`STACK_DEPTH];  // expected stack contents
  idxWord   modelIdx;               // expected index before the next step
  idxWord   frameBase;              // lowerLimit as written over AXI

  stackTop dut0 (
    .clk, .reset, .cmd, .cmdValid, .cmdReady, .resp, .respValid,
    .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready, .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
  );

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      abortRun($sformatf("FAIL %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  // rejected commands leave memory and index alone
  function automatic logic isErrorStatus(input stackOp op, input stackStatus st);
    if (st == stOverflow || st == stBadOffset) return 1'b1;
    return (st == stUnderflow) && (op != opIndexReset) && (op != opIndexPush);
  endfunction

  // word depth+1 places under the index, zero below the bottom
  function automatic stackWord wordBelow(input idxWord idx, input int depth);
    return (int'(idx) > depth) ? shadow[int'(idx) - depth - 1] : '0;
  endfunction

  task automatic updateModel(input tableEntry e);
    if (!isErrorStatus(e.op, e.expStatus)) begin
      case (e.op)
        opPush:    shadow[modelIdx] = e.data;
        opReplace: shadow[modelIdx - 1'b1] = e.data;
        opIndexReset, opIndexPush: begin
          for (int j = int'(modelIdx); j < int'(e.offset); j++) shadow[j] = '0;
          if (e.op == opIndexPush) shadow[e.offset] = e.data;
        end
        opUnderSet: shadow[frameBase + e.offset] = e.data;
        default: ;
      endcase
    end
    modelIdx = e.expIndex;
  endtask

  task automatic addStep(input string name, input stackOp op, input stackWord data,
                         input idxWord offset, input logic dropTos, input stackStatus st,
                         input idxWord idx, input stackWord tos);
    tableEntry e;
    e.name      = name;
    e.op        = op;
    e.data      = data;
    e.offset    = offset;
    e.dropTos   = dropTos;
    e.expStatus = st;
    e.expIndex  = idx;
    e.expTos    = tos;
    steps.push_back(e);
  endtask

  task automatic buildTable();
    addStep("noneReset", opNone, 8'h00, 5'd0, 1'b0, stEmpty, 5'd0, 8'h00);
    addStep("popEmpty", opPop, 8'h00, 5'd0, 1'b0, stUnderflow, 5'd0, 8'h00);
    addStep("replaceEmpty", opReplace, 8'h12, 5'd0, 1'b0, stUnderflow, 5'd0, 8'h00);
    for (int i = 0; i < `STACK_DEPTH; i++) begin  // fill to the top until full
      addStep($sformatf("push%0d", i), opPush, stackWord'(8'h40 + i), 5'd0, 1'b0,
              (i == `STACK_DEPTH - 1) ? stFull : stNone, idxWord'(i + 1),
              stackWord'(8'h40 + i));
    end
    addStep("pushFull", opPush, 8'h33, 5'd0, 1'b0, stOverflow, 5'd31, 8'h5e);
    addStep("popThree", opPop, 8'd2, 5'd0, 1'b0, stNone, 5'd28, 8'h5b);
    addStep("replaceTop", opReplace, 8'ha5, 5'd0, 1'b0, stNone, 5'd28, 8'ha5);
    addStep("popMany", opPop, 8'd27, 5'd0, 1'b0, stEmpty, 5'd0, 8'h00);
    addStep("popBelow", opPop, 8'h00, 5'd0, 1'b0, stUnderflow, 5'd0, 8'h00);
    addStep("resetUp", opIndexReset, 8'h00, 5'd3, 1'b0, stNone, 5'd3, 8'h00);
    addStep("indexPushGap", opIndexPush, 8'h77, 5'd6, 1'b0, stNone, 5'd7, 8'h77);
    addStep("resetDown", opIndexReset, 8'h00, 5'd6, 1'b0, stNone, 5'd6, 8'h00);
    addStep("indexPushTop", opIndexPush, 8'h55, 5'd31, 1'b0, stOverflow, 5'd6, 8'h00);
    addStep("pushAfter", opPush, 8'h11, 5'd0, 1'b0, stNone, 5'd7, 8'h11);
    addStep("resetZero", opIndexReset, 8'h00, 5'd0, 1'b0, stEmpty, 5'd0, 8'h00);
    for (int i = 0; i < 6; i++) begin  // slots 0..5 get a0..a5
      addStep($sformatf("pushFrame%0d", i), opPush, stackWord'(8'ha0 + i), 5'd0, 1'b0,
              stNone, idxWord'(i + 1), stackWord'(8'ha0 + i));
    end
    splitAt = steps.size();
    // frame is slots 1..3 from here on
    addStep("noneLimits", opNone, 8'h00, 5'd0, 1'b0, stNone, 5'd6, 8'ha5);
    addStep("getFrame0", opUnderGet, 8'h00, 5'd0, 1'b0, stNone, 5'd6, 8'ha1);
    addStep("getFrame2", opUnderGet, 8'h00, 5'd2, 1'b0, stNone, 5'd6, 8'ha3);
    addStep("getBadOffset", opUnderGet, 8'h00, 5'd3, 1'b0, stBadOffset, 5'd6, 8'ha5);
    addStep("setKeep", opUnderSet, 8'hc2, 5'd1, 1'b0, stNone, 5'd6, 8'ha5);
    addStep("getSet", opUnderGet, 8'h00, 5'd1, 1'b0, stNone, 5'd6, 8'hc2);
    addStep("setBadOffset", opUnderSet, 8'hbb, 5'd3, 1'b0, stBadOffset, 5'd6, 8'ha5);
    addStep("setDrop5", opUnderSet, 8'hc1, 5'd0, 1'b1, stNone, 5'd5, 8'ha4);
    addStep("setDrop4", opUnderSet, 8'hc3, 5'd2, 1'b1, stEmpty, 5'd4, 8'hc3);
    addStep("setDropLimit", opUnderSet, 8'hee, 5'd0, 1'b1, stUnderflow, 5'd4, 8'hc3);
    addStep("getKept", opUnderGet, 8'h00, 5'd0, 1'b0, stNone, 5'd4, 8'hc1);
    addStep("replaceLimit", opReplace, 8'h66, 5'd0, 1'b0, stUnderflow, 5'd4, 8'hc3);
    addStep("popLimit", opPop, 8'h00, 5'd0, 1'b0, stUnderflow, 5'd4, 8'hc3);
    addStep("pushAbove", opPush, 8'h99, 5'd0, 1'b0, stNone, 5'd5, 8'h99);
    addStep("popToLimit", opPop, 8'h00, 5'd0, 1'b0, stEmpty, 5'd4, 8'hc3);
    addStep("resetBelow", opIndexReset, 8'h00, 5'd2, 1'b0, stUnderflow, 5'd2, 8'hc1);
  endtask

  task automatic applyStep(input tableEntry e);
    int n;
    int expLatency;
    // upward index moves add one cycle per zeroed word
    expLatency = 1;
    if ((e.op == opIndexReset || e.op == opIndexPush) &&
        !isErrorStatus(e.op, e.expStatus) && (e.offset > modelIdx)) begin
      expLatency = 1 + int'(e.offset) - int'(modelIdx);
    end
    n = 0;
    @(negedge clk);
    while (!cmdReady) begin
      @(negedge clk);
      n++;
      if (n > CmdCycles) abortRun({"cmdReady stayed low before ", e.name});
    end
    cmd.op      = e.op;
    cmd.data    = e.data;
    cmd.offset  = e.offset;
    cmd.dropTos = e.dropTos;
    cmdValid    = 1'b1;
    @(negedge clk);  // taken on the rising edge just passed
    cmdValid = 1'b0;
    n = 0;
    while (!respValid) begin  // index moves upward take longer
      @(negedge clk);
      n++;
      if (n > CmdCycles) abortRun({"no response arrived for ", e.name});
    end
    updateModel(e);
    checkValue({e.name, " latency"}, 32'(expLatency), 32'(n + 1));
    checkValue({e.name, " status"}, 32'(e.expStatus), 32'(resp.status));
    checkValue({e.name, " index"}, 32'(e.expIndex), 32'(resp.index));
    checkValue({e.name, " tos"}, 32'(e.expTos), 32'(resp.tos));
    checkValue({e.name, " nos"}, 32'(wordBelow(e.expIndex, 1)), 32'(resp.nos));
    checkValue({e.name, " third"}, 32'(wordBelow(e.expIndex, 2)), 32'(resp.third));
  endtask

  task automatic applySteps(input int first, input int last);
    for (int i = first; i < last; i++) applyStep(steps[i]);
  endtask

  task automatic axiWrite(input logic [31:0] addr, input logic [31:0] data);
    logic awTaken;
    logic wTaken;
    int n;
    @(negedge clk);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wvalid  = 1'b1;
    n = 0;
    while (awvalid || wvalid) begin
      awTaken = awvalid && awready;  // handshake on the coming rising edge
      wTaken  = wvalid && wready;
      @(negedge clk);
      if (awTaken) awvalid = 1'b0;
      if (wTaken) wvalid = 1'b0;
      n++;
      if (n > AxiCycles) abortRun("AXI write address or data was never accepted");
    end
    bready = 1'b1;
    n = 0;
    while (!bvalid) begin
      @(negedge clk);
      n++;
      if (n > AxiCycles) abortRun("AXI write response never arrived");
    end
    checkValue($sformatf("bresp %0h", addr), 32'(RespOkay), 32'(bresp));
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axiRead(input logic [31:0] addr, output logic [31:0] data,
                         output logic [1:0] code);
    int n;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    n = 0;
    while (!arready) begin
      @(negedge clk);
      n++;
      if (n > AxiCycles) abortRun("AXI read address was never accepted");
    end
    @(negedge clk);
    arvalid = 1'b0;
    n = 0;
    while (!rvalid) begin
      @(negedge clk);
      n++;
      if (n > AxiCycles) abortRun("AXI read data never arrived");
    end
    data   = rdata;
    code   = rresp;
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic readExpect(input string name, input logic [31:0] addr,
                            input logic [31:0] expData, input logic [1:0] expCode);
    logic [31:0] data;
    logic [1:0] code;
    axiRead(addr, data, code);
    checkValue({name, " rdata"}, expData, data);
    checkValue({name, " rresp"}, 32'(expCode), 32'(code));
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns
  end

  initial begin : watchdog
    int budget;
    wait (tableReady === 1'b1);
    budget = steps.size() * CmdCycles + AxiOps * 4 * AxiCycles + 10;
    repeat (budget) @(posedge clk);
    abortRun("watchdog expired before the test sequence finished");
  end

  initial begin
    tableEntry lastStep;
    logic [31:0] stateWord;
    reset    = 1'b1;
    cmd      = '0;
    cmdValid = 1'b0;
    awaddr   = '0;
    awvalid  = 1'b0;
    wdata    = '0;
    wvalid   = 1'b0;
    bready   = 1'b0;
    araddr   = '0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    modelIdx  = '0;
    frameBase = '0;
    for (int j = 0; j < `STACK_DEPTH; j++) shadow[j] = '0;
    tableReady = 1'b0;
    buildTable();
    tableReady = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    applySteps(0, splitAt);
    axiWrite(`REG_UNDERFLOW, 32'd4);
    axiWrite(`REG_UPPER, 32'd4);
    axiWrite(`REG_LOWER, 32'd1);
    frameBase = 5'd1;
    readExpect("underflowLimit", `REG_UNDERFLOW, 32'd4, RespOkay);
    readExpect("upperLimit", `REG_UPPER, 32'd4, RespOkay);
    readExpect("lowerLimit", `REG_LOWER, 32'd1, RespOkay);
    applySteps(splitAt, steps.size());

    // state word mirrors the last response
    lastStep  = steps[steps.size() - 1];
    stateWord = 32'(lastStep.expIndex) | (32'(lastStep.expStatus) << `REG_STATE_STATUS_LSB);
    readExpect("state", `REG_STATE, stateWord, RespOkay);
    axiWrite(`REG_STATE, 32'hffff_ffff);  // read-only register ignores it
    readExpect("stateAfterWrite", `REG_STATE, stateWord, RespOkay);
    readExpect("unmapped", 32'h10, 32'h0, RespSlvErr);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: tb/stack_properties.sv
// ----------------------------------------------------------------------
// concurrent checks on the stack handshakes and writes, bound into stackTop
// underflow is left out of the error check as it is also a level status
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "stack_cfg.svh"

module stackProperties (
  input logic                       clk,
  input logic                       reset,
  input logic                       cmdValid,
  input logic                       cmdReady,
  input logic                       respValid,
  input logic [`STACK_IDX_BITS-1:0] index,
  input stackPkg::stackStatus       status,
  input logic                       wrEn,
  input logic [`STACK_IDX_BITS-1:0] wrAddr,
  input logic                       awvalid,
  input logic                       awready,
  input logic                       wvalid,
  input logic                       wready,
  input logic                       bvalid,
  input logic                       bready,
  input logic                       arvalid,
  input logic                       arready,
  input logic                       rvalid,
  input logic                       rready
);

  import stackPkg::*;

  resetState: assert property (@(posedge clk)
    reset |=> !respValid && cmdReady && index == '0 && status == stEmpty && !bvalid && !rvalid)
    else $error("outputs not in reset state after reset");

  // every response follows an accepted command or the last fill cycle
  respCause: assert property (@(posedge clk) disable iff (reset)
    respValid |-> $past(cmdValid && cmdReady) || $past(!cmdReady))
    else $error("respValid without an accepted command or finished fill");

  writeInRange: assert property (@(posedge clk) disable iff (reset)
    wrEn |-> int'(wrAddr) < `STACK_DEPTH)
    else $error("memory write above the top of the stack");

  errorKeepsIndex: assert property (@(posedge clk) disable iff (reset)
    respValid && (status == stOverflow || status == stBadOffset) |-> index == $past(index))
    else $error("error response moved the index");

  awHold: assert property (@(posedge clk) disable iff (reset) awvalid && !awready |=> awvalid)
    else $error("awvalid dropped before awready");
  wHold: assert property (@(posedge clk) disable iff (reset) wvalid && !wready |=> wvalid)
    else $error("wvalid dropped before wready");
  bHold: assert property (@(posedge clk) disable iff (reset) bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");
  arHold: assert property (@(posedge clk) disable iff (reset) arvalid && !arready |=> arvalid)
    else $error("arvalid dropped before arready");
  rHold: assert property (@(posedge clk) disable iff (reset) rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");

endmodule

bind stackTop stackProperties props0 (
  .clk, .reset, .cmdValid, .cmdReady, .respValid, .index, .status,
  .wrEn, .wrAddr,
  .awvalid, .awready, .wvalid, .wready, .bvalid, .bready,
  .arvalid, .arready, .rvalid, .rready
);

// File: verilog/stackTop.sv
// ----------------------------------------------------------------------
// operand stack top level: command port, response port, AXI4-Lite limits
// resp has no back-pressure, respValid is a single-cycle pulse
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "stack_cfg.svh"

module stackTop (
  input  logic                      clk,
  input  logic                      reset,
  input  stackPkg::stackCmd         cmd,
  input  logic                      cmdValid,
  output logic                      cmdReady,
  output stackPkg::stackView        resp,
  output logic                      respValid,
  input  logic [`AXI_ADDR_BITS-1:0] awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [`AXI_DATA_BITS-1:0] wdata,
  input  logic                      wvalid,
  output logic                      wready,
  output logic [1:0]                bresp,
  output logic                      bvalid,
  input  logic                      bready,
  input  logic [`AXI_ADDR_BITS-1:0] araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output logic [`AXI_DATA_BITS-1:0] rdata,
  output logic [1:0]                rresp,
  output logic                      rvalid,
  input  logic                      rready
);

  import stackPkg::*;

  stackLimits limits;
  stackStatus status;
  logic [`STACK_IDX_BITS-1:0] index;

  // core to memory
  logic                       wrEn;
  logic [`STACK_IDX_BITS-1:0] wrAddr;
  logic [`STACK_WIDTH-1:0]    wrData;
  logic [`STACK_IDX_BITS-1:0] topIdx;
  logic [`STACK_IDX_BITS-1:0] peekAddr;
  logic [`STACK_WIDTH-1:0]    tos;
  logic [`STACK_WIDTH-1:0]    nos;
  logic [`STACK_WIDTH-1:0]    third;
  logic [`STACK_WIDTH-1:0]    peekData;

  stackRegs regs0 (
    .clk, .reset,
    .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .limits, .index, .status
  );

  stackCore core0 (
    .clk, .reset,
    .cmd, .cmdValid, .cmdReady, .limits, .resp, .respValid,
    .wrEn, .wrAddr, .wrData, .topIdx, .peekAddr,
    .tos, .nos, .third, .peekData,
    .index, .status
  );

  stackMemory mem0 (
    .clk, .wrEn, .wrAddr, .wrData, .topIdx, .peekAddr,
    .tos, .nos, .third, .peekData
  );

endmodule

// File: verilog/stackRegs.sv
// ----------------------------------------------------------------------
// AXI4-Lite slave, single beat only, full-word writes (no WSTRB)
// limit registers plus read-only index/status, unmapped -> SLVERR
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "stack_cfg.svh"

module stackRegs (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`AXI_ADDR_BITS-1:0]  awaddr,
  input  logic                       awvalid,
  output logic                       awready,
  input  logic [`AXI_DATA_BITS-1:0]  wdata,
  input  logic                       wvalid,
  output logic                       wready,
  output logic [1:0]                 bresp,
  output logic                       bvalid,
  input  logic                       bready,
  input  logic [`AXI_ADDR_BITS-1:0]  araddr,
  input  logic                       arvalid,
  output logic                       arready,
  output logic [`AXI_DATA_BITS-1:0]  rdata,
  output logic [1:0]                 rresp,
  output logic                       rvalid,
  input  logic                       rready,
  output stackPkg::stackLimits       limits,
  input  logic [`STACK_IDX_BITS-1:0] index,
  input  stackPkg::stackStatus       status
);

  localparam int IdxBits = `STACK_IDX_BITS;
  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

  logic awHeld;
  logic wHeld;
  logic [`AXI_ADDR_BITS-1:0] awAddrReg;
  logic [`AXI_DATA_BITS-1:0] wDataReg;

  logic [`AXI_DATA_BITS-1:0] readWord;
  logic readErr;

  // each channel takes one beat, then waits for the response to drain
  assign awready = !awHeld && !bvalid;
  assign wready  = !wHeld && !bvalid;
  assign arready = !rvalid;

  always_ff @(posedge clk) begin
    if (reset) begin
      awHeld <= 1'b0;
      wHeld  <= 1'b0;
      bvalid <= 1'b0;
      bresp  <= RespOkay;
      limits <= '0;
    end else begin
      if (awvalid && awready) begin
        awHeld    <= 1'b1;
        awAddrReg <= awaddr;
      end
      if (wvalid && wready) begin
        wHeld    <= 1'b1;
        wDataReg <= wdata;
      end
      if (awHeld && wHeld) begin  // both halves in, commit
        awHeld <= 1'b0;
        wHeld  <= 1'b0;
        bvalid <= 1'b1;
        bresp  <= RespOkay;
        case (awAddrReg)
          `REG_UNDERFLOW: limits.underflowLimit <= wDataReg[IdxBits-1:0];
          `REG_UPPER:     limits.upperLimit <= wDataReg[IdxBits-1:0];
          `REG_LOWER:     limits.lowerLimit <= wDataReg[IdxBits-1:0];
          `REG_STATE:     ;  // read-only, dropped
          default:        bresp <= RespSlvErr;
        endcase
      end
      if (bvalid && bready) bvalid <= 1'b0;
    end
  end

  always_comb begin
    readWord = '0;
    readErr  = 1'b0;
    case (araddr)
      `REG_UNDERFLOW: readWord[IdxBits-1:0] = limits.underflowLimit;
      `REG_UPPER:     readWord[IdxBits-1:0] = limits.upperLimit;
      `REG_LOWER:     readWord[IdxBits-1:0] = limits.lowerLimit;
      `REG_STATE: begin
        readWord[IdxBits-1:0] = index;
        readWord[`REG_STATE_STATUS_LSB +: 3] = status;
      end
      default: readErr = 1'b1;
    endcase
  end

  // read data one cycle after the AR handshake
  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (arvalid && arready) begin
      rvalid <= 1'b1;
      rdata  <= readWord;
      rresp  <= readErr ? RespSlvErr : RespOkay;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

endmodule

// File: stack/stackCore.sv
// ----------------------------------------------------------------------
// operand stack control: command decode, index and status registers
// index moves upward zero-fill one word per cycle, cmdReady low meanwhile
// errors leave memory and index untouched
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "stack_cfg.svh"

module stackCore (
  input  logic                       clk,
  input  logic                       reset,
  input  stackPkg::stackCmd          cmd,
  input  logic                       cmdValid,
  output logic                       cmdReady,
  input  stackPkg::stackLimits       limits,
  output stackPkg::stackView         resp,
  output logic                       respValid,
  output logic                       wrEn,
  output logic [`STACK_IDX_BITS-1:0] wrAddr,
  output logic [`STACK_WIDTH-1:0]    wrData,
  output logic [`STACK_IDX_BITS-1:0] topIdx,
  output logic [`STACK_IDX_BITS-1:0] peekAddr,
  input  logic [`STACK_WIDTH-1:0]    tos,
  input  logic [`STACK_WIDTH-1:0]    nos,
  input  logic [`STACK_WIDTH-1:0]    third,
  input  logic [`STACK_WIDTH-1:0]    peekData,
  output logic [`STACK_IDX_BITS-1:0] index,
  output stackPkg::stackStatus       status
);

  import stackPkg::*;

  localparam int IdxBits = `STACK_IDX_BITS;
  localparam logic [IdxBits-1:0] MaxIdx = IdxBits'(`STACK_DEPTH);

  typedef enum logic [1:0] {sIdle, sFill, sRespond} coreState;

  coreState state;
  logic accept;

  logic [IdxBits-1:0] fillPtr;    // next slot to clear
  logic [IdxBits-1:0] fillEnd;    // first slot not cleared
  logic [IdxBits-1:0] targetIdx;  // index once the fill is done
  logic [IdxBits-1:0] peekReg;
  logic peekResp;                 // resp.tos comes from the frame port

  // decode of the command on the port
  logic               decErr;
  logic               decWrite;
  logic               decFill;
  logic [IdxBits-1:0] decAddr;
  logic [IdxBits-1:0] decIdx;
  logic [IdxBits-1:0] peekNext;
  stackStatus         decStatus;
  int                 frameSize;
  int                 popRemain;

  function automatic stackStatus levelStatus(input logic [IdxBits-1:0] idx,
                                             input logic [IdxBits-1:0] uLimit);
    if (idx == MaxIdx) return stFull;
    if (idx == uLimit) return stEmpty;
    if (idx < uLimit) return stUnderflow;
    return stNone;
  endfunction

  assign frameSize = int'(limits.upperLimit) - int'(limits.lowerLimit);  // may go negative
  assign popRemain = int'(index) - int'(cmd.data);
  assign peekNext  = limits.lowerLimit + cmd.offset;

  always_comb begin
    decErr    = 1'b0;
    decWrite  = 1'b0;
    decFill   = 1'b0;
    decAddr   = index;
    decIdx    = index;
    decStatus = stNone;
    case (cmd.op)
      opPush: begin
        if (index == MaxIdx) begin
          decErr    = 1'b1;
          decStatus = stOverflow;
        end else begin
          decWrite = 1'b1;
          decIdx   = index + 1'b1;
        end
      end
      opPop: begin
        if (popRemain <= int'(limits.underflowLimit)) begin
          decErr    = 1'b1;
          decStatus = stUnderflow;
        end else begin
          decIdx = IdxBits'(popRemain - 1);
        end
      end
      opReplace: begin
        if (index <= limits.underflowLimit) begin
          decErr    = 1'b1;
          decStatus = stUnderflow;
        end else begin
          decWrite = 1'b1;
          decAddr  = index - 1'b1;
        end
      end
      opIndexReset: begin
        decIdx  = cmd.offset;
        decFill = cmd.offset > index;
      end
      opIndexPush: begin
        if (cmd.offset == MaxIdx) begin
          decErr    = 1'b1;
          decStatus = stOverflow;
        end else begin
          decWrite = 1'b1;          // data lands above the zeroed gap
          decAddr  = cmd.offset;
          decIdx   = cmd.offset + 1'b1;
          decFill  = cmd.offset > index;
        end
      end
      opUnderGet: begin
        if (int'(cmd.offset) >= frameSize) begin
          decErr    = 1'b1;
          decStatus = stBadOffset;
        end
      end
      opUnderSet: begin
        if (int'(cmd.offset) >= frameSize) begin
          decErr    = 1'b1;
          decStatus = stBadOffset;
        end else if (cmd.dropTos && (index == limits.underflowLimit)) begin
          decErr    = 1'b1;
          decStatus = stUnderflow;
        end else begin
          decWrite = 1'b1;
          decAddr  = peekNext;
          if (cmd.dropTos) decIdx = index - 1'b1;
        end
      end
      default: ;  // opNone just refreshes status
    endcase
    if (!decErr) begin
      decStatus = (cmd.op == opUnderGet) ? stNone : levelStatus(decIdx, limits.underflowLimit);
    end
  end

  assign cmdReady = (state != sFill);
  assign accept   = cmdValid && cmdReady;

  // single write port, the fill sequencer owns it while running
  always_comb begin
    if (state == sFill) begin
      wrEn   = 1'b1;
      wrAddr = fillPtr;
      wrData = '0;
    end else begin
      wrEn   = accept && decWrite;
      wrAddr = decAddr;
      wrData = cmd.data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= sIdle;
      index    <= '0;
      status   <= stEmpty;
      peekResp <= 1'b0;
    end else begin
      case (state)
        sFill: begin
          fillPtr <= fillPtr + 1'b1;
          if (fillPtr + 1'b1 == fillEnd) begin  // last zero written this cycle
            index  <= targetIdx;
            status <= levelStatus(targetIdx, limits.underflowLimit);
            state  <= sRespond;
          end
        end
        default: begin
          if (accept) begin
            peekReg  <= peekNext;
            peekResp <= (cmd.op == opUnderGet) && !decErr;
            if (decFill && !decErr) begin
              fillPtr   <= index;
              fillEnd   <= cmd.offset;
              targetIdx <= decIdx;
              state     <= sFill;
            end else begin
              if (!decErr) index <= decIdx;
              status <= decStatus;
              state  <= sRespond;
            end
          end else begin
            state <= sIdle;
          end
        end
      endcase
    end
  end

  assign topIdx   = index;
  assign peekAddr = peekReg;

  assign respValid = (state == sRespond);
  assign resp = '{
    status: status,
    index:  index,
    tos:    peekResp ? peekData : tos,
    nos:    nos,
    third:  third
  };

endmodule

// File: stack/stackMemory.sv
// ----------------------------------------------------------------------
// stack storage, one synchronous write port, combinational reads
// top reads return zero below the bottom, out-of-range peeks return zero
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "stack_cfg.svh"

module stackMemory (
  input  logic                       clk,
  input  logic                       wrEn,
  input  logic [`STACK_IDX_BITS-1:0] wrAddr,
  input  logic [`STACK_WIDTH-1:0]    wrData,
  input  logic [`STACK_IDX_BITS-1:0] topIdx,
  input  logic [`STACK_IDX_BITS-1:0] peekAddr,
  output logic [`STACK_WIDTH-1:0]    tos,
  output logic [`STACK_WIDTH-1:0]    nos,
  output logic [`STACK_WIDTH-1:0]    third,
  output logic [`STACK_WIDTH-1:0]    peekData
);

  localparam int Depth   = `STACK_DEPTH;
  localparam int IdxBits = `STACK_IDX_BITS;

  logic [`STACK_WIDTH-1:0] mem [Depth];
  logic [`STACK_WIDTH-1:0] topWords [3];  // index-1, index-2, index-3

  always_ff @(posedge clk) begin
    if (wrEn && (int'(wrAddr) < Depth)) begin
      mem[wrAddr] <= wrData;
    end
  end

  // three words under the current index
  for (genvar k = 0; k < 3; k++) begin : gTop
    logic [IdxBits-1:0] addr;

    assign addr = topIdx - IdxBits'(k + 1);
    assign topWords[k] = (int'(topIdx) > k) ? mem[addr] : '0;
  end

  assign tos   = topWords[0];
  assign nos   = topWords[1];
  assign third = topWords[2];

  // frame access for underflow get
  assign peekData = (int'(peekAddr) < Depth) ? mem[peekAddr] : '0;

endmodule

// File: common/stackPkg.sv
// ----------------------------------------------------------------------
// types shared by the stack core, its register block and the top level
// widths come from stack_cfg.svh
// ----------------------------------------------------------------------
`include "stack_cfg.svh"

package stackPkg;

  // command port operations
  typedef enum logic [2:0] {
    opNone,        // refresh outputs only
    opPush,
    opPop,         // drops 1+data entries
    opReplace,
    opIndexReset,  // zero-fills when moving up
    opIndexPush,
    opUnderGet,
    opUnderSet
  } stackOp;

  typedef enum logic [2:0] {
    stNone,
    stEmpty,
    stFull,
    stUnderflow,
    stOverflow,
    stBadOffset
  } stackStatus;

  typedef struct packed {
    stackOp                     op;
    logic [`STACK_WIDTH-1:0]    data;
    logic [`STACK_IDX_BITS-1:0] offset;
    logic                       dropTos;  // opUnderSet only
  } stackCmd;

  // response word, one per accepted command
  typedef struct packed {
    stackStatus                 status;
    logic [`STACK_IDX_BITS-1:0] index;
    logic [`STACK_WIDTH-1:0]    tos;
    logic [`STACK_WIDTH-1:0]    nos;
    logic [`STACK_WIDTH-1:0]    third;
  } stackView;

  typedef struct packed {
    logic [`STACK_IDX_BITS-1:0] underflowLimit;
    logic [`STACK_IDX_BITS-1:0] upperLimit;
    logic [`STACK_IDX_BITS-1:0] lowerLimit;
  } stackLimits;

endpackage

// File: common/stack_cfg.svh
// ----------------------------------------------------------------------
// stack geometry and AXI4-Lite register map
// depth is 2^STACK_IDX_BITS - 1 entries, limits share the index width
// ----------------------------------------------------------------------
`ifndef STACK_CFG_SVH
`define STACK_CFG_SVH

`define STACK_WIDTH    8
`define STACK_IDX_BITS 5
`define STACK_DEPTH    ((1 << `STACK_IDX_BITS) - 1)

`define AXI_ADDR_BITS 32
`define AXI_DATA_BITS 32

`define REG_UNDERFLOW 32'h0
`define REG_UPPER     32'h4
`define REG_LOWER     32'h8
`define REG_STATE     32'hC
// REG_STATE layout: index in the low bits, status from this bit up
`define REG_STATE_STATUS_LSB 8

`endif
